// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - hw/cpu_isa_pkg.sv
      - hw/cpu_alu_pkg.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/cpu_core.sv
  - target: simulation
    files:
      - dv/cpu_core_assert.sv
      - dv/cpu_core_tb.sv

// File: dv/cpu_core_assert.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_assert #(
	parameter int IMEM_DEPTH = 256
) (
	input  wire logic                  Clock,
	input  wire logic                  rst_i,
	input  wire logic                  run_i,
	input  wire logic                  imem_we_i,
	input  wire cpu_isa_pkg::word_t    imem_addr_i,
	input  wire cpu_isa_pkg::word_t    imem_data_i,
	input  wire logic                  wb_valid_i,
	input  wire cpu_isa_pkg::reg_idx_t wb_rd_i,
	input  wire cpu_isa_pkg::word_t    wb_data_i,
	input  wire cpu_alu_pkg::flags_t   flags_i
);
	import cpu_isa_pkg::*;
	import cpu_alu_pkg::*;

	localparam int ADDR_W = $clog2(IMEM_DEPTH);

	word_t prog [IMEM_DEPTH];
	word_t sregs [REG_COUNT];
	flags_t sflags;
	int exec_idx;
	int fetch_idx;
	logic ran;
	int fail_count = 0;

	logic found;
	int next_idx;
	word_t instr;
	opcode_t opc;
	word_t op_a;
	word_t op_b;
	logic [WORD_W:0] sum;
	logic ovf;
	reg_idx_t exp_rd;
	word_t exp_data;
	flags_t exp_flags;
	logic fetch_writes;

	function automatic logic writes_reg(word_t w);
		return opcode_t'(w[OPC_LSB +: OPC_W]) inside
			{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LI};
	endfunction

	// ########################################################################
	// shadow model
	// ########################################################################

	// next instruction in program order that must write back
	always_comb begin
		found = 1'b0;
		next_idx = exec_idx;
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			if (!found && i >= exec_idx && writes_reg(prog[i])) begin
				found = 1'b1;
				next_idx = i;
			end
		end
		instr = prog[next_idx];
		opc = opcode_t'(instr[OPC_LSB +: OPC_W]);
		exp_rd = instr[RD_LSB +: 3];
		op_a = sregs[exp_rd];
		op_b = sregs[instr[RS_LSB +: 3]];
		if (opc == OP_ADDI) begin
			op_b = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
		end else if (opc == OP_LI) begin
			op_b = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
		end
		sum = '0;
		ovf = 1'b0;
		case (opc)
			OP_ADD, OP_ADDI: begin
				sum = {1'b0, op_a} + {1'b0, op_b};
				exp_data = sum[WORD_W-1:0];
				ovf = (op_a[WORD_W-1] == op_b[WORD_W-1]) &&
					(exp_data[WORD_W-1] != op_a[WORD_W-1]);
			end
			OP_SUB: begin
				sum = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
				exp_data = sum[WORD_W-1:0];
				ovf = (op_a[WORD_W-1] != op_b[WORD_W-1]) &&
					(exp_data[WORD_W-1] != op_a[WORD_W-1]);
			end
			OP_AND:  exp_data = op_a & op_b;
			OP_OR:   exp_data = op_a | op_b;
			OP_XOR:  exp_data = op_a ^ op_b;
			default: exp_data = op_b;
		endcase
		exp_flags = sflags;
		if (opc != OP_LI) begin
			exp_flags[FLAG_Z] = (exp_data == '0);
			exp_flags[FLAG_S] = exp_data[WORD_W-1];
			exp_flags[FLAG_C] = sum[WORD_W];
			exp_flags[FLAG_V] = ovf;
		end
	end

	assign fetch_writes = run_i && writes_reg(prog[fetch_idx]);

	always_ff @(posedge Clock) begin
		if (imem_we_i) begin
			prog[imem_addr_i[ADDR_W-1:0]] <= imem_data_i;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				sregs[i] <= '0;
			end
			sflags <= '0;
			exec_idx <= 0;
			fetch_idx <= 0;
			ran <= 1'b0;
		end else begin
			if (run_i) begin
				ran <= 1'b1;
				fetch_idx <= (fetch_idx + 1) % IMEM_DEPTH;
			end
			if (wb_valid_i) begin
				sregs[exp_rd] <= exp_data;
				sflags <= exp_flags;
				exec_idx <= next_idx + 1;
			end
		end
	end

	// ########################################################################
	// assertions
	// ########################################################################

	a_idle: assert property (@(posedge Clock) disable iff (rst_i)
		(!ran && !run_i) |-> (!wb_valid_i && flags_i == '0))
		else begin
			fail_count++;
			$error("ERR flags_o 0x%h wb_valid_o 0x%h, expected 0 before run",
				$sampled(flags_i), $sampled(wb_valid_i));
		end

	a_timing: assert property (@(posedge Clock) disable iff (rst_i)
		wb_valid_i == $past(fetch_writes, 3))
		else begin
			fail_count++;
			$error("wb_valid_o pulse does not match the word fetched three cycles before");
		end

	a_rd: assert property (@(posedge Clock) disable iff (rst_i)
		wb_valid_i |-> (found && wb_rd_i == exp_rd))
		else begin
			fail_count++;
			$error("ERR wb_rd_o 0x%h expected 0x%h", $sampled(wb_rd_i), $sampled(exp_rd));
		end

	a_data: assert property (@(posedge Clock) disable iff (rst_i)
		wb_valid_i |-> wb_data_i == exp_data)
		else begin
			fail_count++;
			$error("ERR wb_data_o 0x%h expected 0x%h",
				$sampled(wb_data_i), $sampled(exp_data));
		end

	// between writebacks the flags hold the last architectural value
	a_flags: assert property (@(posedge Clock) disable iff (rst_i)
		flags_i == (wb_valid_i ? exp_flags : sflags))
		else begin
			fail_count++;
			$error("ERR flags_o 0x%h expected 0x%h", $sampled(flags_i),
				$sampled(wb_valid_i ? exp_flags : sflags));
		end

endmodule

bind cpu_core cpu_core_assert #(
	.IMEM_DEPTH(IMEM_DEPTH)
) chk0 (
	.Clock(Clock),
	.rst_i(rst_i),
	.run_i(run_i),
	.imem_we_i(imem_we_i),
	.imem_addr_i(imem_addr_i),
	.imem_data_i(imem_data_i),
	.wb_valid_i(wb_valid_o),
	.wb_rd_i(wb_rd_o),
	.wb_data_i(wb_data_o),
	.flags_i(flags_o)
);

`default_nettype wire

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;
	import cpu_isa_pkg::*;
	import cpu_alu_pkg::*;

	localparam int IMEM_DEPTH = 256;
	localparam int WAIT_LIMIT = 64;

	logic Clock;
	logic rst_i;
	logic run_i;
	logic imem_we_i;
	word_t imem_addr_i;
	word_t imem_data_i;
	logic wb_valid_o;
	reg_idx_t wb_rd_o;
	word_t wb_data_o;
	flags_t flags_o;

	logic [15:0] lfsr;
	word_t prog_q [$];
	int wb_count = 0;
	int test_count;
	int timeouts;

	cpu_core #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) dut0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.run_i(run_i),
		.imem_we_i(imem_we_i),
		.imem_addr_i(imem_addr_i),
		.imem_data_i(imem_data_i),
		.wb_valid_o(wb_valid_o),
		.wb_rd_o(wb_rd_o),
		.wb_data_o(wb_data_o),
		.flags_o(flags_o)
	);

	always #5 Clock = ~Clock;

	// count writeback pulses
	always @(negedge Clock) begin
		if (wb_valid_o === 1'b1) begin
			wb_count++;
		end
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [15:0] take_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic word_t enc(opcode_t op, reg_idx_t rd, logic [7:0] low);
		return {op, 1'b0, rd, low};
	endfunction

	function automatic word_t enc_rr(opcode_t op, reg_idx_t rd, reg_idx_t rs);
		return enc(op, rd, {rs, 5'b00000});
	endfunction

	function automatic int count_writes();
		int n;
		n = 0;
		foreach (prog_q[i]) begin
			if (opcode_t'(prog_q[i][15:12]) inside
				{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LI}) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic step();
		@(posedge Clock);
		#1;
	endtask

	task automatic apply_reset();
		rst_i = 1'b1;
		run_i = 1'b0;
		imem_we_i = 1'b0;
		repeat (5) step();
		rst_i = 1'b0;
	endtask

	task automatic load_program();
		foreach (prog_q[i]) begin
			imem_we_i = 1'b1;
			imem_addr_i = word_t'(i);
			imem_data_i = prog_q[i];
			step();
		end
		imem_we_i = 1'b0;
	endtask

	task automatic run_for(int n);
		run_i = 1'b1;
		repeat (n) step();
		run_i = 1'b0;
	endtask

	task automatic wait_writes(int base, int n);
		int cycles;
		cycles = 0;
		while (wb_count - base < n && cycles < WAIT_LIMIT) begin
			cycles++;
			step();
		end
		if (wb_count - base < n) begin
			timeouts++;
			$display("timeout: only %0d of %0d writebacks arrived", wb_count - base, n);
		end
	endtask

	// ########################################################################
	// test sequence
	// ########################################################################

	task automatic run_program(string name, int split);
		int base;
		int expected;
		int fails_before;
		apply_reset();
		// core must stay quiet while run_i is low
		repeat (4) step();
		load_program();
		expected = count_writes();
		base = wb_count;
		fails_before = dut0.chk0.fail_count;
		if (split > 0 && split < prog_q.size()) begin
			run_for(split);
			repeat (3) step();
			run_for(prog_q.size() - split);
		end else begin
			run_for(prog_q.size());
		end
		wait_writes(base, expected);
		repeat (4) step();
		test_count++;
		$display("test %0d %s: %0d of %0d writebacks, %0d assertion failures",
			test_count, name, wb_count - base, expected,
			dut0.chk0.fail_count - fails_before);
	endtask

	task automatic build_alu_program();
		opcode_t alu_ops [6];
		int sel;
		reg_idx_t rd;
		reg_idx_t rs;
		alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
		prog_q.delete();
		for (int r = 0; r < REG_COUNT; r++) begin
			prog_q.push_back(enc(OP_LI, reg_idx_t'(r), 8'(take_bits(8))));
		end
		for (int k = 0; k < 16; k++) begin
			sel = take_bits(3) % 6;
			rd = reg_idx_t'(take_bits(3));
			rs = reg_idx_t'(take_bits(3));
			if (alu_ops[sel] == OP_ADDI) begin
				prog_q.push_back(enc(OP_ADDI, rd, {3'b000, 5'(take_bits(5))}));
			end else begin
				prog_q.push_back(enc_rr(alu_ops[sel], rd, rs));
			end
		end
		// dependent chain through the bypass
		prog_q.push_back(enc_rr(OP_ADD, 3'd1, 3'd2));
		prog_q.push_back(enc_rr(OP_SUB, 3'd3, 3'd1));
		prog_q.push_back(enc_rr(OP_XOR, 3'd1, 3'd3));
		prog_q.push_back(enc(OP_ADDI, 3'd1, 8'h1D));
	endtask

	initial begin
		logic [15:0] v;
		Clock = 1'b0;
		rst_i = 1'b1;
		run_i = 1'b0;
		imem_we_i = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;
		lfsr = 16'd4510;
		test_count = 0;
		timeouts = 0;

		prog_q.delete();
		run_program("reset idle", 0);

		v = take_bits(7);
		prog_q = '{enc(OP_LI, 3'd0, 8'h35), enc(OP_LI, 3'd1, 8'hA5),
			enc(OP_LI, 3'd2, 8'h7F), enc(OP_LI, 3'd3, 8'h80),
			enc(OP_LI, 3'd4, 8'(take_bits(8))), enc(OP_LI, 3'd5, {1'b1, v[6:0]})};
		run_program("load immediate", 0);

		build_alu_program();
		run_program("alu ops", 0);

		// wrap-around add, overflow by doubling, borrow, zero, LI holding flags
		prog_q = '{enc(OP_LI, 3'd0, 8'hFF), enc(OP_LI, 3'd1, 8'h01),
			enc_rr(OP_ADD, 3'd0, 3'd1), enc(OP_LI, 3'd2, 8'h40)};
		repeat (9) prog_q.push_back(enc_rr(OP_ADD, 3'd2, 3'd2));
		prog_q.push_back(enc(OP_LI, 3'd7, 8'h12));
		prog_q.push_back(enc(OP_LI, 3'd5, 8'h03));
		prog_q.push_back(enc(OP_LI, 3'd6, 8'h05));
		prog_q.push_back(enc_rr(OP_SUB, 3'd5, 3'd6));
		prog_q.push_back(enc_rr(OP_SUB, 3'd6, 3'd6));
		prog_q.push_back(enc(OP_LI, 3'd4, 8'h9C));
		run_program("flags", 0);

		prog_q = '{enc(OP_LI, 3'd1, 8'h05), 16'h0000, enc_rr(OP_ADD, 3'd1, 3'd1),
			16'h0000, 16'h0000, enc_rr(OP_SUB, 3'd2, 3'd1), enc(OP_LI, 3'd3, 8'hFF),
			16'h0000, enc_rr(OP_XOR, 3'd3, 3'd1), enc(OP_ADDI, 3'd3, 8'h01)};
		run_program("stall and nop", 4);

		$display("%0d tests, %0d assertion failures, %0d timeouts",
			test_count, dut0.chk0.fail_count, timeouts);
		if (dut0.chk0.fail_count == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/cpu_alu_pkg.sv
`default_nettype none

package cpu_alu_pkg;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		// passes operand b through and leaves the flags alone
		ALU_PASS = 3'd5
	} alu_op_t;

	localparam int FLAG_W = 4;

	typedef logic [FLAG_W-1:0] flags_t;

	// bit positions inside flags_t
	localparam int FLAG_Z = 0;
	localparam int FLAG_S = 1;
	localparam int FLAG_C = 2;
	localparam int FLAG_V = 3;

endpackage

`default_nettype wire

// File: hw/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
	parameter int IMEM_DEPTH = 256
) (
	input  wire logic                  Clock,
	input  wire logic                  rst_i,
	input  wire logic                  run_i,
	input  wire logic                  imem_we_i,
	input  wire cpu_isa_pkg::word_t    imem_addr_i,
	input  wire cpu_isa_pkg::word_t    imem_data_i,
	output logic                       wb_valid_o,
	output cpu_isa_pkg::reg_idx_t      wb_rd_o,
	output cpu_isa_pkg::word_t         wb_data_o,
	output cpu_alu_pkg::flags_t        flags_o
);
	import cpu_isa_pkg::*;
	import cpu_alu_pkg::*;

	logic f_valid;
	word_t f_instr;

	logic d_valid;
	alu_op_t d_op;
	reg_idx_t d_rd;
	word_t d_a;
	word_t d_b;
	logic d_we;

	logic x_we;
	reg_idx_t x_rd;
	word_t x_result;

	fetch_stage #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) fetch0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.run_i(run_i),
		.imem_we_i(imem_we_i),
		.imem_addr_i(imem_addr_i),
		.imem_data_i(imem_data_i),
		.f_valid_o(f_valid),
		.f_instr_o(f_instr)
	);

	decode_stage decode0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.f_valid_i(f_valid),
		.f_instr_i(f_instr),
		.x_we_i(x_we),
		.x_rd_i(x_rd),
		.x_result_i(x_result),
		.d_valid_o(d_valid),
		.d_op_o(d_op),
		.d_rd_o(d_rd),
		.d_a_o(d_a),
		.d_b_o(d_b),
		.d_we_o(d_we)
	);

	execute_stage execute0 (
		.Clock(Clock),
		.rst_i(rst_i),
		.d_valid_i(d_valid),
		.d_op_i(d_op),
		.d_rd_i(d_rd),
		.d_a_i(d_a),
		.d_b_i(d_b),
		.d_we_i(d_we),
		.x_we_o(x_we),
		.x_rd_o(x_rd),
		.x_result_o(x_result),
		.wb_valid_o(wb_valid_o),
		.wb_rd_o(wb_rd_o),
		.wb_data_o(wb_data_o),
		.flags_o(flags_o)
	);

endmodule

`default_nettype wire

// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int WORD_W = 16;
	localparam int REG_IDX_W = 3;
	localparam int REG_COUNT = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// ########################################################################
	// instruction layout
	// ########################################################################

	// opcode sits in the top nibble
	localparam int OPC_LSB = 12;
	localparam int OPC_W = 4;

	// rd is both destination and first source
	localparam int RD_LSB = 8;
	localparam int RS_LSB = 5;
	localparam int IMM5_W = 5;
	localparam int IMM8_W = 8;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LI   = 4'h7
	} opcode_t;

endpackage

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  wire logic                 Clock,
	input  wire logic                 rst_i,
	input  wire logic                 f_valid_i,
	input  wire cpu_isa_pkg::word_t   f_instr_i,
	input  wire logic                 x_we_i,
	input  wire cpu_isa_pkg::reg_idx_t x_rd_i,
	input  wire cpu_isa_pkg::word_t   x_result_i,
	output logic                      d_valid_o,
	output cpu_alu_pkg::alu_op_t      d_op_o,
	output cpu_isa_pkg::reg_idx_t     d_rd_o,
	output cpu_isa_pkg::word_t        d_a_o,
	output cpu_isa_pkg::word_t        d_b_o,
	output logic                      d_we_o
);
	import cpu_isa_pkg::*;
	import cpu_alu_pkg::*;

	word_t regs [REG_COUNT];

	opcode_t opcode;
	reg_idx_t rd_idx;
	reg_idx_t rs_idx;
	word_t rd_val;
	word_t rs_val;
	word_t imm5_ext;
	word_t imm8_ext;
	alu_op_t op;
	word_t b_sel;
	logic we;

	assign opcode = opcode_t'(f_instr_i[OPC_LSB +: OPC_W]);
	assign rd_idx = f_instr_i[RD_LSB +: REG_IDX_W];
	assign rs_idx = f_instr_i[RS_LSB +: REG_IDX_W];

	assign imm5_ext = {{(WORD_W-IMM5_W){f_instr_i[IMM5_W-1]}}, f_instr_i[IMM5_W-1:0]};
	assign imm8_ext = {{(WORD_W-IMM8_W){f_instr_i[IMM8_W-1]}}, f_instr_i[IMM8_W-1:0]};

	// ########################################################################
	// register file and bypass
	// ########################################################################

	// written at the edge that ends execute
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (x_we_i) begin
			regs[x_rd_i] <= x_result_i;
		end
	end

	// only the instruction in execute can be ahead of the file
	assign rd_val = (x_we_i && x_rd_i == rd_idx) ? x_result_i : regs[rd_idx];
	assign rs_val = (x_we_i && x_rd_i == rs_idx) ? x_result_i : regs[rs_idx];

	// ########################################################################
	// opcode decode
	// ########################################################################

	always_comb begin
		op = ALU_PASS;
		b_sel = rs_val;
		we = 1'b1;
		case (opcode)
			OP_ADD:  op = ALU_ADD;
			OP_SUB:  op = ALU_SUB;
			OP_AND:  op = ALU_AND;
			OP_OR:   op = ALU_OR;
			OP_XOR:  op = ALU_XOR;
			OP_ADDI: begin
				op = ALU_ADD;
				b_sel = imm5_ext;
			end
			OP_LI:   b_sel = imm8_ext;
			// NOP and unused codes write nothing
			default: we = 1'b0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst_i) begin
			d_valid_o <= 1'b0;
			d_we_o <= 1'b0;
		end else begin
			d_valid_o <= f_valid_i;
			d_we_o <= f_valid_i & we;
		end
	end

	always_ff @(posedge Clock) begin
		d_op_o <= op;
		d_rd_o <= rd_idx;
		d_a_o <= rd_val;
		d_b_o <= b_sel;
	end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  wire logic                  Clock,
	input  wire logic                  rst_i,
	input  wire logic                  d_valid_i,
	input  wire cpu_alu_pkg::alu_op_t  d_op_i,
	input  wire cpu_isa_pkg::reg_idx_t d_rd_i,
	input  wire cpu_isa_pkg::word_t    d_a_i,
	input  wire cpu_isa_pkg::word_t    d_b_i,
	input  wire logic                  d_we_i,
	output logic                       x_we_o,
	output cpu_isa_pkg::reg_idx_t      x_rd_o,
	output cpu_isa_pkg::word_t         x_result_o,
	output logic                       wb_valid_o,
	output cpu_isa_pkg::reg_idx_t      wb_rd_o,
	output cpu_isa_pkg::word_t         wb_data_o,
	output cpu_alu_pkg::flags_t        flags_o
);
	import cpu_isa_pkg::*;
	import cpu_alu_pkg::*;

	logic sub;
	logic arith;
	word_t b_eff;
	logic [WORD_W:0] sum;
	logic ovf;
	word_t result;
	flags_t flags_nxt;

	// ########################################################################
	// ALU
	// ########################################################################

	// subtract is a + ~b + 1 on the same adder
	assign sub = (d_op_i == ALU_SUB);
	assign arith = (d_op_i == ALU_ADD) || sub;
	assign b_eff = sub ? ~d_b_i : d_b_i;
	assign sum = {1'b0, d_a_i} + {1'b0, b_eff} + {{WORD_W{1'b0}}, sub};

	// signed overflow when both inputs agree in sign and the sum does not
	assign ovf = (d_a_i[WORD_W-1] == b_eff[WORD_W-1]) &&
		(sum[WORD_W-1] != d_a_i[WORD_W-1]);

	always_comb begin
		case (d_op_i)
			ALU_ADD, ALU_SUB: result = sum[WORD_W-1:0];
			ALU_AND:          result = d_a_i & d_b_i;
			ALU_OR:           result = d_a_i | d_b_i;
			ALU_XOR:          result = d_a_i ^ d_b_i;
			default:          result = d_b_i;
		endcase
	end

	always_comb begin
		flags_nxt = '0;
		flags_nxt[FLAG_Z] = (result == '0);
		flags_nxt[FLAG_S] = result[WORD_W-1];
		flags_nxt[FLAG_C] = arith & sum[WORD_W];
		flags_nxt[FLAG_V] = arith & ovf;
	end

	// same-cycle path back to the register file and bypass
	assign x_we_o = d_valid_i & d_we_i;
	assign x_rd_o = d_rd_i;
	assign x_result_o = result;

	always_ff @(posedge Clock) begin
		if (rst_i) begin
			wb_valid_o <= 1'b0;
			flags_o <= '0;
		end else begin
			wb_valid_o <= x_we_o;
			if (d_valid_i && d_op_i != ALU_PASS) begin
				flags_o <= flags_nxt;
			end
		end
	end

	always_ff @(posedge Clock) begin
		wb_rd_o <= d_rd_i;
		wb_data_o <= result;
	end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
	parameter int IMEM_DEPTH = 256
) (
	input  wire logic               Clock,
	input  wire logic               rst_i,
	input  wire logic               run_i,
	input  wire logic               imem_we_i,
	input  wire cpu_isa_pkg::word_t imem_addr_i,
	input  wire cpu_isa_pkg::word_t imem_data_i,
	output logic                    f_valid_o,
	output cpu_isa_pkg::word_t      f_instr_o
);
	import cpu_isa_pkg::*;

	localparam int ADDR_W = $clog2(IMEM_DEPTH);

	word_t imem [IMEM_DEPTH];
	logic [ADDR_W-1:0] pc;

	// ########################################################################
	// instruction memory
	// ########################################################################

	// load port writes one word per cycle while halted
	always_ff @(posedge Clock) begin
		if (imem_we_i) begin
			imem[imem_addr_i[ADDR_W-1:0]] <= imem_data_i;
		end
		if (run_i) begin
			f_instr_o <= imem[pc];
		end
	end

	// ########################################################################
	// program counter
	// ########################################################################

	// pc is ADDR_W bits, so it wraps at IMEM_DEPTH by itself
	always_ff @(posedge Clock) begin
		if (rst_i) begin
			pc <= '0;
			f_valid_o <= 1'b0;
		end else begin
			f_valid_o <= run_i;
			if (run_i) begin
				pc <= pc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
hw/cpu_isa_pkg.sv
hw/cpu_alu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_core.sv
dv/cpu_core_assert.sv
dv/cpu_core_tb.sv
